// ==== Makefile ====
# Verilator build and run for the hazard unit testbench

VERILATOR ?= verilator
TOP       ?= hazardUnitTb
FILELIST  ?= sources.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0
PASS_MSG  ?= Simulation finished: PASS
FAIL_MSG  ?= Simulation finished: FAIL

SRCS := $(shell grep -v '^+' $(FILELIST))
HDRS := $(wildcard source/*.svh)
BIN  := $(OBJ_DIR)/V$(TOP)

.PHONY: all run check clean

all: $(BIN)

# Rebuilt only when a source, header or the file list changes
$(BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJ_DIR)

run: $(BIN)
	-./$(BIN) > $(LOG) 2>&1
	@cat $(LOG)
	@! grep -q "$(FAIL_MSG)" $(LOG)

check: run
	@grep -q "$(PASS_MSG)" $(LOG)
	@echo "check ok"

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== dv/hazardUnitTb.sv ====
`timescale 1ns/10ps
`include "pipe_consts.svh"

module hazardUnitTb import pipePkg::*; ();

    localparam int numInstr  = 2000;
    // Worst case is a few stall cycles plus a shadow bubble per instruction
    localparam int maxCycles = numInstr * 5;

    typedef struct packed {
        logic [`DATA_W-1:0] instr;
        logic [`REG_W-1:0]  rd;
        logic               wr;
        logic               mem;
        logic [`DATA_W-1:0] addr;
    } modelRec_t;

    logic               clk;
    logic               arstN;
    logic               inValid;
    logic [`DATA_W-1:0] instr;
    logic [`REG_W-1:0]  rd;
    logic               writesReg;
    logic               memEnable;
    logic [`DATA_W-1:0] reg1Data;
    logic [`DATA_W-1:0] imm;
    logic               issueValid;
    logic [`DATA_W-1:0] issueInstr;
    logic               bubble;
    logic               pcStall;
    fwdSel_t            fwdRs;
    fwdSel_t            fwdRt;
    logic               creditReturn;

    // Reference model state
    modelRec_t          queueModel[$];
    modelRec_t          hist[4];
    logic               shadowModel;
    logic               expIssueValid;
    logic               expBubble;
    logic               expPcStall;
    logic               expCredit;
    logic [`DATA_W-1:0] expInstr;
    fwdSel_t            expFwdRs;
    fwdSel_t            expFwdRt;
    logic [`DATA_W-1:0] sentInstr[$];

    integer seed;
    int     errors = 0;
    int     credits;
    int     sent = 0;
    int     issued = 0;
    int     returned = 0;
    int     cycleCount = 0;
    int     regStalls = 0;
    int     memStalls = 0;
    int     shadows = 0;

    tbClock clkGen (
        .clk(clk),
        .arstN(arstN)
    );

    hazardUnitTop dut (
        .clk(clk),
        .arstN(arstN),
        .inValid(inValid),
        .instr(instr),
        .rd(rd),
        .writesReg(writesReg),
        .memEnable(memEnable),
        .reg1Data(reg1Data),
        .imm(imm),
        .issueValid(issueValid),
        .issueInstr(issueInstr),
        .bubble(bubble),
        .pcStall(pcStall),
        .fwdRs(fwdRs),
        .fwdRt(fwdRt),
        .creditReturn(creditReturn)
    );

    function automatic logic [31:0] nextRand();
        return $random(seed);
    endfunction

    function automatic logic writesTo(modelRec_t e, logic [`REG_W-1:0] src);
        return e.wr && (e.rd == src);
    endfunction

    // Load in ID, or any producer in MEM or WB, cannot be forwarded
    function automatic logic needsStall(logic [`REG_W-1:0] src);
        return (writesTo(hist[0], src) && hist[0].mem)
            || writesTo(hist[2], src) || writesTo(hist[3], src);
    endfunction

    function automatic fwdSel_t forwardFor(logic [`REG_W-1:0] src);
        if (writesTo(hist[0], src)) return FWD_EX_EX;
        if (writesTo(hist[1], src)) return FWD_MEM_EX;
        return FWD_NONE;
    endfunction

    function automatic logic addrBusy(logic [`DATA_W-1:0] a);
        logic hit;
        hit = 1'b0;
        for (int i = 0; i < 4; i++) begin
            hit = hit | (hist[i].mem && (hist[i].addr == a));
        end
        return hit;
    endfunction

    task automatic stopOnError(string why);
        errors++;
        $display("%s", why);
        $display("Simulation finished: FAIL");
        $fatal(1, "run stopped at the first error");
    endtask

    task automatic expectEqual(string name, logic [15:0] got, logic [15:0] exp);
        assert (got === exp) else stopOnError($sformatf(
            "mismatch at %0t: %s got 0x%0h, expected 0x%0h", $time, name, got, exp));
    endtask

    task automatic verifyOutputs();
        expectEqual("issueValid", 16'(issueValid), 16'(expIssueValid));
        expectEqual("issueInstr", issueInstr, expInstr);
        expectEqual("bubble", 16'(bubble), 16'(expBubble));
        expectEqual("pcStall", 16'(pcStall), 16'(expPcStall));
        expectEqual("fwdRs", 16'(fwdRs), 16'(expFwdRs));
        expectEqual("fwdRt", 16'(fwdRt), 16'(expFwdRt));
        expectEqual("creditReturn", 16'(creditReturn), 16'(expCredit));
    endtask

    // One decision at the coming rising edge followed by the state update
    task automatic stepModel(logic pushed, modelRec_t rec);
        modelRec_t  h;
        logic [4:0] op;
        logic       headV;
        logic       nop;
        logic       jb;
        logic       regHz;
        logic       memHz;
        logic       doIssue;
        h = '0;
        headV = (queueModel.size() != 0);
        if (headV) begin
            h = queueModel[0];
        end
        op = h.instr[15:11];
        nop = (op == `OP_NOP);
        jb = (h.instr[15:13] == `CLS_JUMP) || (h.instr[15:13] == `CLS_BRANCH);
        regHz = headV && !nop && (needsStall(h.instr[10:8]) || needsStall(h.instr[7:5]));
        memHz = headV && !nop && h.mem && addrBusy(h.addr);
        doIssue = headV && !shadowModel && !(regHz || memHz);

        expIssueValid = doIssue;
        expInstr      = doIssue ? h.instr : '0;
        expBubble     = headV && (shadowModel || regHz || memHz);
        expPcStall    = headV && !shadowModel && (regHz || memHz);
        expFwdRs      = doIssue ? forwardFor(h.instr[10:8]) : FWD_NONE;
        expFwdRt      = doIssue ? forwardFor(h.instr[7:5]) : FWD_NONE;
        expCredit     = doIssue;

        if (!shadowModel && regHz) regStalls++;
        if (!shadowModel && memHz && !regHz) memStalls++;
        if (headV && shadowModel) shadows++;

        for (int i = 3; i > 0; i--) begin
            hist[i] = hist[i-1];
        end
        hist[0] = doIssue ? h : '0;
        if (doIssue) begin
            void'(queueModel.pop_front());
        end
        shadowModel = doIssue && jb;
        if (pushed) begin
            queueModel.push_back(rec);
        end
    endtask

    always @(posedge clk) begin
        if (arstN) begin
            cycleCount = cycleCount + 1;
            if (cycleCount > maxCycles) begin
                stopOnError($sformatf("timeout after %0d cycles, %0d of %0d instructions issued",
                    cycleCount, issued, numInstr));
            end
        end
    end

    initial begin
        logic [31:0] r;
        logic [4:0]  op;
        logic        push;
        modelRec_t   rec;
        seed = 42;
        inValid = 1'b0;
        instr = '0;
        rd = '0;
        writesReg = 1'b0;
        memEnable = 1'b0;
        reg1Data = '0;
        imm = '0;
        credits = `FIFO_DEPTH;
        shadowModel = 1'b0;
        for (int i = 0; i < 4; i++) begin
            hist[i] = '0;
        end
        expIssueValid = 1'b0;
        expInstr = '0;
        expBubble = 1'b0;
        expPcStall = 1'b0;
        expCredit = 1'b0;
        expFwdRs = FWD_NONE;
        expFwdRt = FWD_NONE;

        wait (arstN === 1'b1);
        verifyOutputs();
        while (issued < numInstr) begin
            @(negedge clk);
            verifyOutputs();
            if (creditReturn) begin
                credits++;
                returned++;
            end
            if (issueValid) begin
                assert (sentInstr.size() > 0) else stopOnError("issue seen with nothing sent");
                expectEqual("issueInstr order", issueInstr, sentInstr.pop_front());
                issued++;
            end

            push = 1'b0;
            rec = '0;
            r = nextRand();
            if (sent < numInstr && credits > 0 && r[2:0] != 3'd0) begin
                r = nextRand();
                // Opcode mix biased toward NOP, JR, jump and branch
                case (r[2:0])
                    3'd0:    op = `OP_NOP;
                    3'd1:    op = `OP_JR;
                    3'd2:    op = {`CLS_JUMP, r[28:27]};
                    3'd3:    op = {`CLS_BRANCH, r[28:27]};
                    default: op = r[31:27];
                endcase
                // Registers 0 to 3 only so that collisions are frequent
                instr     = {op, 1'b0, r[9:8], 1'b0, r[11:10], r[16:12]};
                rd        = {1'b0, r[18:17]};
                writesReg = r[19] | r[20];
                memEnable = (r[22:21] == 2'd0);
                reg1Data  = {12'h010, r[24:23], 2'b00};
                imm       = {12'h000, r[26:25], 2'b00};
                rec.instr = instr;
                rec.rd    = rd;
                rec.wr    = writesReg;
                rec.mem   = memEnable;
                rec.addr  = reg1Data + imm;
                sentInstr.push_back(instr);
                push = 1'b1;
                credits--;
                sent++;
            end
            inValid = push;
            stepModel(push, rec);
        end

        assert (returned == numInstr) else stopOnError("credit returns differ from pops");
        assert (credits == `FIFO_DEPTH) else stopOnError("sender did not regain all credits");
        assert (regStalls > 0 && memStalls > 0 && shadows > 0)
            else stopOnError("stimulus did not reach every hazard kind");
        $display("%0d instructions in %0d cycles, %0d register, %0d memory stalls, %0d shadows",
            issued, cycleCount, regStalls, memStalls, shadows);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

// ==== dv/tbClock.sv ====
`timescale 1ns/10ps

module tbClock #(
    parameter int periodNs    = 20,
    parameter int resetCycles = 3
) (
    output logic clk,
    output logic arstN
);

    initial begin
        clk = 1'b0;
        forever #(periodNs / 2) clk = ~clk;
    end

    // Reset released on a falling edge away from the sampling edge
    initial begin
        arstN = 1'b0;
        repeat (resetCycles) @(posedge clk);
        @(negedge clk);
        arstN = 1'b1;
    end

endmodule

// ==== source/creditFifo.sv ====
`timescale 1ns/10ps

module creditFifo #(
    parameter type payload_t = logic,
    parameter int  depth     = 4
) (
    input  logic     clk,
    input  logic     arstN,
    input  logic     push,
    input  payload_t din,
    input  logic     pop,
    output logic     headValid,
    output payload_t head,
    output logic     creditReturn
);

    localparam int ptrW = (depth > 1) ? $clog2(depth) : 1;
    localparam int cntW = $clog2(depth + 1);

    payload_t         mem [depth];
    logic [ptrW-1:0]  wrPtr;
    logic [ptrW-1:0]  rdPtr;
    logic [cntW-1:0]  count;
    logic             full;

    assign full      = (count == cntW'(depth));
    assign headValid = (count != '0);
    assign head      = mem[rdPtr];

    // Entry storage written on push
    always_ff @(posedge clk) begin
        if (push) begin
            mem[wrPtr] <= din;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            wrPtr        <= '0;
            rdPtr        <= '0;
            count        <= '0;
            creditReturn <= 1'b0;
        end else begin
            if (push) begin
                wrPtr <= (wrPtr == ptrW'(depth - 1)) ? '0 : wrPtr + 1'b1;
            end
            if (pop) begin
                rdPtr <= (rdPtr == ptrW'(depth - 1)) ? '0 : rdPtr + 1'b1;
            end
            if (push && !pop) begin
                count <= count + 1'b1;
            end else if (pop && !push) begin
                count <= count - 1'b1;
            end
            // One credit back to the sender per freed entry
            creditReturn <= pop;
        end
    end

    // Sender overran its credits
    assert property (@(posedge clk) disable iff (!arstN) !(push && full));
    assert property (@(posedge clk) disable iff (!arstN) !(pop && !headValid));

endmodule

// ==== source/hazardDetector.sv ====
`timescale 1ns/10ps
`include "pipe_consts.svh"

module hazardDetector import pipePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               headValid,
    input  logic [`REG_W-1:0]  rs,
    input  logic [`REG_W-1:0]  rt,
    input  logic               isNopOp,
    input  logic [`DATA_W-1:0] memAddr,
    input  logic               headMem,
    input  histEntry_t         idEntry,
    input  histEntry_t         exEntry,
    input  histEntry_t         memEntry,
    input  histEntry_t         wbEntry,
    output logic               regHazard,
    output logic               memHazard,
    output fwdSel_t            fwdRs,
    output fwdSel_t            fwdRt
);

    // True when the entry writes the given register
    function automatic logic writesSrc(histEntry_t e, logic [`REG_W-1:0] src);
        return e.writesReg && (e.rd == src);
    endfunction

    // Values that cannot be forwarded in time
    function automatic logic srcHazard(logic [`REG_W-1:0] src);
        return (writesSrc(idEntry, src) && idEntry.isLoad)
            || writesSrc(memEntry, src)
            || writesSrc(wbEntry, src);
    endfunction

    function automatic fwdSel_t srcFwd(logic [`REG_W-1:0] src);
        fwdSel_t sel;
        sel = FWD_NONE;
        // Youngest producer wins
        if (writesSrc(idEntry, src)) begin
            sel = FWD_EX_EX;
        end else if (writesSrc(exEntry, src)) begin
            sel = FWD_MEM_EX;
        end
        return sel;
    endfunction

    function automatic logic addrHit(histEntry_t e);
        return e.memEnable && (e.addr == memAddr);
    endfunction

    logic rawRs;
    logic rawRt;
    logic addrConflict;

    assign rawRs = srcHazard(rs);
    assign rawRt = srcHazard(rt);

    assign addrConflict = addrHit(idEntry) | addrHit(exEntry)
                        | addrHit(memEntry) | addrHit(wbEntry);

    // NOP never stalls
    assign regHazard = headValid & ~isNopOp & (rawRs | rawRt);
    assign memHazard = headValid & ~isNopOp & headMem & addrConflict;

    assign fwdRs = srcFwd(rs);
    assign fwdRt = srcFwd(rt);

    assert property (@(posedge clk) disable iff (!arstN)
        (headValid && isNopOp) |-> !(regHazard || memHazard));

endmodule

// ==== source/hazardUnitTop.sv ====
`timescale 1ns/10ps
`include "pipe_consts.svh"

module hazardUnitTop import pipePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               inValid,
    input  logic [`DATA_W-1:0] instr,
    input  logic [`REG_W-1:0]  rd,
    input  logic               writesReg,
    input  logic               memEnable,
    input  logic [`DATA_W-1:0] reg1Data,
    input  logic [`DATA_W-1:0] imm,
    output logic               issueValid,
    output logic [`DATA_W-1:0] issueInstr,
    output logic               bubble,
    output logic               pcStall,
    output fwdSel_t            fwdRs,
    output fwdSel_t            fwdRt,
    output logic               creditReturn
);

    instrRec_t          inRec;
    instrRec_t          head;
    logic               headValid;
    logic               pop;
    logic [`REG_W-1:0]  rs;
    logic [`REG_W-1:0]  rt;
    logic               isNopOp;
    logic               isJumpBranch;
    logic               isLoad;
    logic [`DATA_W-1:0] memAddr;
    logic               regHazard;
    logic               memHazard;
    fwdSel_t            fwdRsComb;
    fwdSel_t            fwdRtComb;
    histEntry_t         slotIn;
    histEntry_t         idEntry;
    histEntry_t         exEntry;
    histEntry_t         memEntry;
    histEntry_t         wbEntry;

    assign inRec = '{instr: instr, rd: rd, writesReg: writesReg, memEnable: memEnable,
                     reg1Data: reg1Data, imm: imm};

    creditFifo #(
        .payload_t(instrRec_t),
        .depth(`FIFO_DEPTH)
    ) uFifo (
        .clk(clk),
        .arstN(arstN),
        .push(inValid),
        .din(inRec),
        .pop(pop),
        .headValid(headValid),
        .head(head),
        .creditReturn(creditReturn)
    );

    instrDecoder uDecoder (
        .head(head),
        .rs(rs),
        .rt(rt),
        .isNopOp(isNopOp),
        .isJumpBranch(isJumpBranch),
        .isLoad(isLoad),
        .memAddr(memAddr)
    );

    hazardDetector uDetector (
        .clk(clk),
        .arstN(arstN),
        .headValid(headValid),
        .rs(rs),
        .rt(rt),
        .isNopOp(isNopOp),
        .memAddr(memAddr),
        .headMem(head.memEnable),
        .idEntry(idEntry),
        .exEntry(exEntry),
        .memEntry(memEntry),
        .wbEntry(wbEntry),
        .regHazard(regHazard),
        .memHazard(memHazard),
        .fwdRs(fwdRsComb),
        .fwdRt(fwdRtComb)
    );

    stageTracker uTracker (
        .clk(clk),
        .arstN(arstN),
        .slotIn(slotIn),
        .idEntry(idEntry),
        .exEntry(exEntry),
        .memEntry(memEntry),
        .wbEntry(wbEntry)
    );

    issueControl uIssue (
        .clk(clk),
        .arstN(arstN),
        .headValid(headValid),
        .head(head),
        .isJumpBranch(isJumpBranch),
        .isLoad(isLoad),
        .memAddr(memAddr),
        .regHazard(regHazard),
        .memHazard(memHazard),
        .fwdRs(fwdRsComb),
        .fwdRt(fwdRtComb),
        .pop(pop),
        .slotIn(slotIn),
        .issueValid(issueValid),
        .issueInstr(issueInstr),
        .bubble(bubble),
        .pcStall(pcStall),
        .fwdRsOut(fwdRs),
        .fwdRtOut(fwdRt)
    );

endmodule

// ==== source/instrDecoder.sv ====
`timescale 1ns/10ps
`include "pipe_consts.svh"

module instrDecoder import pipePkg::*; (
    input  instrRec_t          head,
    output logic [`REG_W-1:0]  rs,
    output logic [`REG_W-1:0]  rt,
    output logic               isNopOp,
    output logic               isJumpBranch,
    output logic               isLoad,
    output logic [`DATA_W-1:0] memAddr
);

    logic [4:0] opcode;
    logic [2:0] opClass;

    assign opcode  = head.instr[15:11];
    assign opClass = head.instr[15:13];

    // Source register fields
    assign rs = head.instr[10:8];
    assign rt = head.instr[7:5];

    assign isNopOp = (opcode == `OP_NOP);

    // JR sits in the jump class
    always_comb begin
        case (opClass)
            `CLS_JUMP:   isJumpBranch = 1'b1;
            `CLS_BRANCH: isJumpBranch = 1'b1;
            default:     isJumpBranch = 1'b0;
        endcase
    end

    // A memory access that writes a register is a load
    assign isLoad = head.memEnable & head.writesReg;

    // Effective address is base register plus immediate
    assign memAddr = head.reg1Data + head.imm;

endmodule

// ==== source/issueControl.sv ====
`timescale 1ns/10ps
`include "pipe_consts.svh"

module issueControl import pipePkg::*; (
    input  logic               clk,
    input  logic               arstN,
    input  logic               headValid,
    input  instrRec_t          head,
    input  logic               isJumpBranch,
    input  logic               isLoad,
    input  logic [`DATA_W-1:0] memAddr,
    input  logic               regHazard,
    input  logic               memHazard,
    input  fwdSel_t            fwdRs,
    input  fwdSel_t            fwdRt,
    output logic               pop,
    output histEntry_t         slotIn,
    output logic               issueValid,
    output logic [`DATA_W-1:0] issueInstr,
    output logic               bubble,
    output logic               pcStall,
    output fwdSel_t            fwdRsOut,
    output fwdSel_t            fwdRtOut
);

    logic shadow;
    logic hazard;
    logic issue;

    assign hazard = regHazard | memHazard;

    // Shadow bubble takes priority over the hazard hold
    assign issue = headValid & ~shadow & ~hazard;
    assign pop   = issue;

    always_comb begin
        slotIn = '0;
        if (issue) begin
            slotIn.rd        = head.rd;
            slotIn.writesReg = head.writesReg;
            slotIn.isLoad    = isLoad;
            slotIn.memEnable = head.memEnable;
            slotIn.addr      = memAddr;
        end
    end

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            shadow     <= 1'b0;
            issueValid <= 1'b0;
            issueInstr <= '0;
            bubble     <= 1'b0;
            pcStall    <= 1'b0;
            fwdRsOut   <= FWD_NONE;
            fwdRtOut   <= FWD_NONE;
        end else begin
            // Shadow lasts one decision even when that cycle is idle
            shadow     <= issue & isJumpBranch;
            issueValid <= issue;
            issueInstr <= issue ? head.instr : '0;
            bubble     <= headValid & (shadow | hazard);
            pcStall    <= headValid & ~shadow & hazard;
            fwdRsOut   <= issue ? fwdRs : FWD_NONE;
            fwdRtOut   <= issue ? fwdRt : FWD_NONE;
        end
    end

    // Popped head must not show up as a stall one cycle later
    assert property (@(posedge clk) disable iff (!arstN) pop |=> !pcStall);

endmodule

// ==== source/pipePkg.sv ====
`include "pipe_consts.svh"

package pipePkg;

    // Decoded record as it arrives from the front end
    typedef struct packed {
        logic [`DATA_W-1:0] instr;
        logic [`REG_W-1:0]  rd;
        logic               writesReg;
        logic               memEnable;
        // Base register value for the effective address
        logic [`DATA_W-1:0] reg1Data;
        logic [`DATA_W-1:0] imm;
    } instrRec_t;

    // Forwarding path chosen for one source operand
    typedef enum logic [1:0] {
        FWD_NONE   = 2'd0,
        FWD_EX_EX  = 2'd1,
        FWD_MEM_EX = 2'd2
    } fwdSel_t;

    // One issued slot in the pipeline history
    // An all-zero entry is a bubble or an idle slot
    typedef struct packed {
        logic [`REG_W-1:0]  rd;
        logic               writesReg;
        logic               isLoad;
        logic               memEnable;
        logic [`DATA_W-1:0] addr;
    } histEntry_t;

endpackage

// ==== source/pipe_consts.svh ====
`ifndef PIPE_CONSTS_SVH
`define PIPE_CONSTS_SVH

// Datapath and register index widths
`define DATA_W 16
`define REG_W 3

// Buffer entries and the initial credit count of the sender
`define FIFO_DEPTH 4

// History depth covering the ID, EX, MEM and WB slots
`define HIST_DEPTH 4

// Opcodes taken from instr[15:11]
`define OP_NOP 5'b00001
`define OP_JR 5'b00111

// Control classes taken from instr[15:13]
`define CLS_JUMP 3'b001
`define CLS_BRANCH 3'b011

`endif

// ==== source/stageTracker.sv ====
`timescale 1ns/10ps
`include "pipe_consts.svh"

module stageTracker import pipePkg::*; (
    input  logic       clk,
    input  logic       arstN,
    input  histEntry_t slotIn,
    output histEntry_t idEntry,
    output histEntry_t exEntry,
    output histEntry_t memEntry,
    output histEntry_t wbEntry
);

    // Index 0 is the youngest slot in ID
    histEntry_t hist [`HIST_DEPTH];

    always_ff @(posedge clk or negedge arstN) begin
        if (!arstN) begin
            for (int i = 0; i < `HIST_DEPTH; i++) begin
                hist[i] <= '0;
            end
        end else begin
            hist[0] <= slotIn;
            for (int i = 1; i < `HIST_DEPTH; i++) begin
                hist[i] <= hist[i-1];
            end
        end
    end

    assign idEntry  = hist[0];
    assign exEntry  = hist[1];
    assign memEntry = hist[2];
    assign wbEntry  = hist[3];

endmodule

// ==== sources.f ====
+incdir+source
source/pipePkg.sv
source/creditFifo.sv
source/instrDecoder.sv
source/stageTracker.sv
source/hazardDetector.sv
source/issueControl.sv
source/hazardUnitTop.sv
dv/tbClock.sv
dv/hazardUnitTb.sv
